//--- dv/exec_tb.sv
`timescale 1ns/1ps

module exec_tb;

    logic               clk;
    logic               rst;
    logic               in_valid;
    exu_pkg::exu_in_t   in_rec;
    logic               out_valid;
    exu_pkg::exu_out_t  out;
    exu_pkg::redirect_t redirect;
    logic               fence_i;

    // vectors and expected responses, filled before the run.
    exu_pkg::exu_in_t   vec_in[$];
    exu_pkg::exu_out_t  exp_out[$];
    exu_pkg::redirect_t exp_redir[$];
    logic               exp_fence[$];
    string              vec_tag[$];

    exu_pkg::exu_out_t  held_out;   // record the DUT must keep while idle.
    logic               loaded;
    logic               pending;
    int                 nvec;
    int                 drv_idx;
    int                 pend_idx;
    int                 err_count;
    int                 err_before;
    int                 checked;
    int                 tests_pass;
    int                 tests_fail;
    int                 limit;

    tb_clkgen u_clkgen (
        .clk (clk),
        .rst (rst)
    );

    exec_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in        (in_rec),
        .out_valid (out_valid),
        .out       (out),
        .redirect  (redirect),
        .fence_i   (fence_i)
    );

    // ==================================================
    // helpers
    // ==================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_out(input exu_pkg::exu_out_t got, input exu_pkg::exu_out_t exp,
                             input string what);
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %0t %0s: out got %h/%h/%h/%h/%h, expected %h/%h/%h/%h/%h",
                     $time, what, got.result, got.csr_wdata, got.store_data, got.rd,
                     got.mem_op, exp.result, exp.csr_wdata, exp.store_data, exp.rd,
                     exp.mem_op);
        end
    endtask

    task automatic check_redirect(input exu_pkg::redirect_t got,
                                  input exu_pkg::redirect_t exp, input string what);
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %0t %0s: redirect got %b/%h, expected %b/%h",
                     $time, what, got.valid, got.target, exp.valid, exp.target);
        end
    endtask

    task automatic check_pulse(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %0t %0s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input int idx, input string tag);
        if (err_count == err_before) begin
            tests_pass++;
            $display("test %0d %0s: pass", idx, tag);
        end else begin
            tests_fail++;
            $display("test %0d %0s: fail", idx, tag);
        end
    endtask

    task automatic load_vectors();
        int                 fd;
        int                 r;
        string              line;
        logic [63:0]        tag;
        logic [31:0]        pc;
        logic [31:0]        imm;
        logic [31:0]        src1;
        logic [31:0]        src2;
        logic [31:0]        csr;
        logic [31:0]        res;
        logic [31:0]        csrw;
        logic [31:0]        tgt;
        logic [15:0]        ops;
        logic [4:0]         flags;
        logic [7:0]         rd;
        logic               rv;
        logic               fen;
        exu_pkg::exu_in_t   v;
        exu_pkg::exu_out_t  o;
        exu_pkg::redirect_t d;
        fd = $fopen("dv/exec_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/exec_testdata.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                r = $fgets(line, fd);
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    r = $sscanf(line, "%s %h %h %h %h %h %h %b %h %h %h %b %h %b", tag, pc,
                                imm, src1, src2, csr, ops, flags, rd, res, csrw, rv, tgt, fen);
                    if (r != 14) begin
                        err_count++;
                        $display("malformed vector line in the data file: %s", line);
                    end else begin
                        v = '0;
                        v.pc          = pc;
                        v.imm         = imm;
                        v.src1        = src1;
                        v.src2        = src2;
                        v.csr_data    = csr;
                        v.alu_op      = exu_pkg::alu_op_e'(ops[15:12]);
                        v.br_op       = exu_pkg::br_op_e'(ops[11:8]);
                        v.csr_op      = exu_pkg::csr_op_e'(ops[5:4]);
                        v.mem_op      = exu_pkg::mem_op_e'(ops[1:0]);
                        v.src1_is_pc  = flags[4];
                        v.src2_is_imm = flags[3];
                        v.is_ecall    = flags[2];
                        v.is_mret     = flags[1];
                        v.is_fence_i  = flags[0];
                        v.rd          = rd[4:0];
                        o.result      = res;
                        o.csr_wdata   = csrw;
                        o.store_data  = src2;       // store data, rd and mem_op pass through.
                        o.rd          = rd[4:0];
                        o.mem_op      = v.mem_op;
                        d.valid       = rv;
                        d.target      = tgt;
                        vec_in.push_back(v);
                        exp_out.push_back(o);
                        exp_redir.push_back(d);
                        exp_fence.push_back(fen);
                        vec_tag.push_back($sformatf("%0s", tag));
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_vectors();
        logic [31:0] rng;
        int          gap;
        rng = 32'd1;
        @(negedge rst);
        // outputs are held by reset up to this point.
        err_before = err_count;
        check_out(out, '0, "reset");
        check_redirect(redirect, '0, "reset");
        check_pulse(out_valid, 1'b0, "out_valid after reset");
        check_pulse(fence_i, 1'b0, "fence_i after reset");
        finish_test(0, "reset");
        for (int i = 0; i < nvec; i++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_rec   <= vec_in[i];
            drv_idx  <= i;
            rng = xorshift32(rng);
            gap = int'(rng[1:0]);   // zero gives back to back.
            repeat (gap) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        wait (checked == nvec);
        repeat (4) @(posedge clk);
    endtask

    // ==================================================
    // response checker, one cycle behind the strobe
    // ==================================================

    always @(negedge clk) begin
        if (rst == 1'b0) begin
            if (pending) begin
                err_before = err_count;
                check_pulse(out_valid, 1'b1, {vec_tag[pend_idx], " out_valid"});
                check_pulse(fence_i, exp_fence[pend_idx], {vec_tag[pend_idx], " fence_i"});
                check_out(out, exp_out[pend_idx], vec_tag[pend_idx]);
                check_redirect(redirect, exp_redir[pend_idx], vec_tag[pend_idx]);
                finish_test(pend_idx + 1, vec_tag[pend_idx]);
                held_out = exp_out[pend_idx];
                checked++;
            end else begin
                check_out(out, held_out, "out held on an idle cycle");
                check_pulse(out_valid, 1'b0, "out_valid on an idle cycle");
                check_pulse(redirect.valid, 1'b0, "redirect.valid on an idle cycle");
                check_pulse(fence_i, 1'b0, "fence_i on an idle cycle");
            end
            pending  = in_valid;   // sampled by the DUT on the next edge.
            pend_idx = drv_idx;
        end
    end

    initial begin
        wait (loaded === 1'b1);
        limit = nvec * 8 + 64;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        in_valid   = 1'b0;
        in_rec     = '0;
        held_out   = '0;
        pending    = 1'b0;
        drv_idx    = 0;
        pend_idx   = 0;
        err_count  = 0;
        err_before = 0;
        checked    = 0;
        tests_pass = 0;
        tests_fail = 0;
        load_vectors();
        nvec   = vec_in.size();
        loaded = 1'b1;
        if (nvec == 0) begin
            $display("no test vectors were read, nothing to run");
            $display("Test FAILED");
            $finish;
        end else begin
            run_vectors();
            $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                     tests_pass, tests_fail, err_count);
            if (err_count == 0 && tests_fail == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

endmodule

//--- dv/exec_testdata.txt
# tag pc imm src1 src2 csr_data ops(alu br csr mem) flags(pc imm ecall mret fence_i) rd
# then expected: result csr_wdata redirect.valid redirect.target fence_i
auipc   00001000 00012000 deadbeef 00000000 00000000 0000 11000 05 00013000 00000000 0 00000000 0
addi    00001004 fffffffc 00000010 00000000 00000000 0000 01000 06 0000000c 00000000 0 00000000 0
add     00001008 00000000 7fffffff 00000001 00000000 0000 00000 07 80000000 00000000 0 00000000 0
sub     0000100c 00000000 00000005 00000007 00000000 1000 00000 08 fffffffe 00000000 0 00000000 0
sll     00001010 00000000 00000001 00000024 00000000 2000 00000 09 00000010 00000000 0 00000000 0
slt     00001014 00000000 ffffffff 00000001 00000000 3000 00000 0a 00000001 00000000 0 00000000 0
sltu    00001018 00000000 ffffffff 00000001 00000000 4000 00000 0b 00000000 00000000 0 00000000 0
xor     0000101c 00000000 f0f0f0f0 ff00ff00 00000000 5000 00000 0c 0ff00ff0 00000000 0 00000000 0
srl     00001020 00000000 80000000 00000004 00000000 6000 00000 0d 08000000 00000000 0 00000000 0
sra     00001024 00000000 80000000 00000004 00000000 7000 00000 0e f8000000 00000000 0 00000000 0
or      00001028 00000000 f0f0f0f0 0f0f0000 00000000 8000 00000 0f fffff0f0 00000000 0 00000000 0
and     0000102c 00000000 f0f0f0f0 ff00ff00 00000000 9000 00000 10 f000f000 00000000 0 00000000 0
lui     00001030 12345000 00000000 00000000 00000000 a000 01000 11 12345000 00000000 0 00000000 0
slti    00001034 00000001 fffffff0 00000000 00000000 3000 01000 12 00000001 00000000 0 00000000 0
srai    00001038 0000001f 80000000 00000000 00000000 7000 01000 13 ffffffff 00000000 0 00000000 0
beq_t   00002000 fffffff8 00000005 00000005 00000000 0100 00000 00 0000000a 00000000 1 00001ff8 0
beq_n   00002004 00000010 00000005 00000006 00000000 0100 00000 00 0000000b 00000000 0 00000000 0
bne_t   00002008 00000010 00000005 00000006 00000000 0200 00000 00 0000000b 00000000 1 00002018 0
bne_n   0000200c 00000010 00000005 00000005 00000000 0200 00000 00 0000000a 00000000 0 00000000 0
blt_t   00002010 00000010 80000000 00000001 00000000 0300 00000 00 80000001 00000000 1 00002020 0
blt_n   00002014 00000010 00000001 80000000 00000000 0300 00000 00 80000001 00000000 0 00000000 0
bge_t   00002018 00000010 00000001 80000000 00000000 0400 00000 00 80000001 00000000 1 00002028 0
bge_n   0000201c 00000010 80000000 00000001 00000000 0400 00000 00 80000001 00000000 0 00000000 0
bltu_t  00002020 00000010 00000001 80000000 00000000 0500 00000 00 80000001 00000000 1 00002030 0
bltu_n  00002024 00000010 80000000 00000001 00000000 0500 00000 00 80000001 00000000 0 00000000 0
bgeu_t  00002028 00000010 80000000 00000001 00000000 0600 00000 00 80000001 00000000 1 00002038 0
bgeu_n  0000202c 00000010 00000001 80000000 00000000 0600 00000 00 80000001 00000000 0 00000000 0
bge_eq  00002030 00000010 ffffffff ffffffff 00000000 0400 00000 00 fffffffe 00000000 1 00002040 0
jal     00003000 00000100 00000000 00000000 00000000 0700 00000 01 00003004 00000000 1 00003100 0
jalr_o  00003010 00000003 00004000 00000000 00000000 0800 00000 01 00003014 00000000 1 00004002 0
jalr_e  00003020 fffffffc 00005008 00000000 00000000 0800 00000 01 00003024 00000000 1 00005004 0
ecall   00004000 00000000 00000000 00000000 00000100 0000 00100 00 00000000 00000000 1 00000100 0
mret    00000200 00000000 00000000 00000000 00001234 0000 00010 00 00000000 00000000 1 00001234 0
csrrw   00004004 00000000 000000aa 00000000 00000f00 0010 00000 07 000000aa 000000aa 0 00000000 0
csrrs   00004008 00000000 000000aa 00000000 00000f0f 0020 00000 08 000000aa 00000faf 0 00000000 0
load    0000400c 00000010 00001000 00000000 00000000 0001 01000 0a 00001010 00000000 0 00000000 0
store   00004010 00000014 00001000 cafef00d 00000000 0002 01000 00 00001014 00000000 0 00000000 0
fence1  00005000 00000000 00000000 00000000 00000000 0000 00001 00 00000000 00000000 0 00000000 1
fence2  00005004 00000000 00000000 00000000 00000000 0000 00001 00 00000000 00000000 0 00000000 1

//--- dv/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period.
    end

    // reset held for 16 rising edges, released on an edge.
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
    input  exu_pkg::alu_op_e op,
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    output logic [31:0]      y
);

    logic [4:0]  shamt;
    logic        lt_signed;
    logic        lt_unsigned;
    logic [31:0] sum;
    logic [31:0] diff;

    assign shamt       = b[4:0];   // rv32i uses the low five bits.
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;
    assign sum         = a + b;
    assign diff        = a - b;

    always_comb begin
        y = 32'd0;
        case (op)
            exu_pkg::alu_add: begin
                y = sum;
            end
            exu_pkg::alu_sub: begin
                y = diff;
            end
            exu_pkg::alu_sll: begin
                y = a << shamt;
            end
            exu_pkg::alu_slt: begin
                y = {31'd0, lt_signed};
            end
            exu_pkg::alu_sltu: begin
                y = {31'd0, lt_unsigned};
            end
            exu_pkg::alu_xor: begin
                y = a ^ b;
            end
            exu_pkg::alu_srl: begin
                y = a >> shamt;
            end
            exu_pkg::alu_sra: begin
                y = $unsigned($signed(a) >>> shamt);   // sign fill.
            end
            exu_pkg::alu_or: begin
                y = a | b;
            end
            exu_pkg::alu_and: begin
                y = a & b;
            end
            exu_pkg::alu_pass_b: begin
                y = b;
            end
            default: begin
                y = 32'd0;
            end
        endcase
    end

endmodule

//--- hdl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  exu_pkg::br_op_e    br_op,
    input  logic               is_ecall,
    input  logic               is_mret,
    input  logic [31:0]        pc,
    input  logic [31:0]        imm,
    input  logic [31:0]        src1,
    input  logic [31:0]        src2,
    input  logic [31:0]        csr_data,
    output exu_pkg::redirect_t redirect
);

    logic [31:0] base;
    logic [31:0] sum;
    logic        taken;

    // jalr is register relative, everything else pc relative.
    assign base = (br_op == exu_pkg::br_jalr) ? src1 : pc;
    assign sum  = base + imm;

    always_comb begin
        case (br_op)
            exu_pkg::br_beq:  taken = (src1 == src2);
            exu_pkg::br_bne:  taken = (src1 != src2);
            exu_pkg::br_blt:  taken = ($signed(src1) < $signed(src2));
            exu_pkg::br_bge:  taken = ($signed(src1) >= $signed(src2));
            exu_pkg::br_bltu: taken = (src1 < src2);
            exu_pkg::br_bgeu: taken = (src1 >= src2);
            exu_pkg::br_jal:  taken = 1'b1;
            exu_pkg::br_jalr: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    always_comb begin
        redirect = '0;
        if (is_ecall || is_mret) begin
            redirect.valid  = 1'b1;
            redirect.target = csr_data;   // trap vector or mepc.
        end else if (taken) begin
            redirect.valid  = 1'b1;
            redirect.target = (br_op == exu_pkg::br_jalr) ? {sum[31:1], 1'b0} : sum;
        end
    end

endmodule

//--- hdl/exec_top.sv
`timescale 1ns/1ps

module exec_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  exu_pkg::exu_in_t   in,
    output logic               out_valid,
    output exu_pkg::exu_out_t  out,
    output exu_pkg::redirect_t redirect,
    output logic               fence_i
);

    // execute stage, one cycle from accept to result.
    exu u_exu (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in        (in),
        .out_valid (out_valid),
        .out       (out),
        .redirect  (redirect),
        .fence_i   (fence_i)
    );

endmodule

//--- hdl/exu.sv
`timescale 1ns/1ps

module exu (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  exu_pkg::exu_in_t   in,
    output logic               out_valid,
    output exu_pkg::exu_out_t  out,
    output exu_pkg::redirect_t redirect,
    output logic               fence_i
);

    // ==================================================
    // operand select and datapath
    // ==================================================

    logic [31:0]        alu_a;
    logic [31:0]        alu_b;
    logic [31:0]        alu_y;
    logic [31:0]        pc_plus4;
    logic               is_jump;
    logic [31:0]        csr_wdata;
    exu_pkg::redirect_t redirect_d;
    exu_pkg::exu_out_t  out_d;

    assign alu_a = in.src1_is_pc  ? in.pc  : in.src1;
    assign alu_b = in.src2_is_imm ? in.imm : in.src2;

    alu u_alu (
        .op (in.alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    branch_unit u_branch_unit (
        .br_op    (in.br_op),
        .is_ecall (in.is_ecall),
        .is_mret  (in.is_mret),
        .pc       (in.pc),
        .imm      (in.imm),
        .src1     (in.src1),
        .src2     (in.src2),
        .csr_data (in.csr_data),
        .redirect (redirect_d)
    );

    assign pc_plus4 = in.pc + 32'd4;   // link value.
    assign is_jump  = (in.br_op == exu_pkg::br_jal) || (in.br_op == exu_pkg::br_jalr);

    always_comb begin
        case (in.csr_op)
            exu_pkg::csr_rw: csr_wdata = in.src1;
            exu_pkg::csr_rs: csr_wdata = in.src1 | in.csr_data;
            default:         csr_wdata = 32'd0;
        endcase
    end

    assign out_d.result     = is_jump ? pc_plus4 : alu_y;
    assign out_d.csr_wdata  = csr_wdata;
    assign out_d.store_data = in.src2;
    assign out_d.rd         = in.rd;
    assign out_d.mem_op     = in.mem_op;

    // ==================================================
    // output registers
    // ==================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            out       <= '0;
            redirect  <= '0;
            fence_i   <= 1'b0;
        end else begin
            out_valid <= in_valid;
            fence_i   <= in_valid & in.is_fence_i;
            redirect  <= in_valid ? redirect_d : '0;   // strobe only on accept.
            if (in_valid) begin
                out <= out_d;
            end
        end
    end

endmodule

//--- hdl/exu_pkg.sv
package exu_pkg;

    // ==================================================
    // operation encodings
    // ==================================================

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10   // lui.
    } alu_op_e;

    typedef enum logic [3:0] {
        br_none = 4'd0,
        br_beq  = 4'd1,
        br_bne  = 4'd2,
        br_blt  = 4'd3,
        br_bge  = 4'd4,
        br_bltu = 4'd5,
        br_bgeu = 4'd6,
        br_jal  = 4'd7,
        br_jalr = 4'd8
    } br_op_e;

    typedef enum logic [1:0] {
        csr_none = 2'd0,
        csr_rw   = 2'd1,
        csr_rs   = 2'd2
    } csr_op_e;

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_op_e;

    // ==================================================
    // stage records
    // ==================================================

    // decoded instruction from the decoder.
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] csr_data;   // csr read value, also ecall/mret target.
        alu_op_e     alu_op;
        br_op_e      br_op;
        csr_op_e     csr_op;
        mem_op_e     mem_op;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        is_ecall;
        logic        is_mret;
        logic        is_fence_i;
        logic [4:0]  rd;
    } exu_in_t;

    // writeback and memory record for the load/store stage.
    typedef struct packed {
        logic [31:0] result;
        logic [31:0] csr_wdata;
        logic [31:0] store_data;
        logic [4:0]  rd;
        mem_op_e     mem_op;
    } exu_out_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage

//--- list.f
hdl/exu_pkg.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/exu.sv
hdl/exec_top.sv
dv/tb_clkgen.sv
dv/exec_tb.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, then scan the simulation log for the fail message.
verilator --binary --timing --top-module exec_tb -f list.f -o exec_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/exec_sim > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
